/* rtl/lcd_ahb_pkg.sv */
// Shared types and constants for the LCD AHB-Lite slave.
// Offsets are 12-bit, relative to a 4 KiB-aligned block base.
// All accesses are 32-bit words; HSIZE and HBURST are not decoded.

package lcd_ahb_pkg;

   // ============================================================
   // bus types
   // ============================================================
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [1:0]  htrans_t;
   typedef logic [3:0]  reg_idx_t;
   typedef logic [6:0]  pal_idx_t;

   // transfer type codes
   localparam htrans_t HTRANS_IDLE   = 2'b00;
   localparam htrans_t HTRANS_BUSY   = 2'b01;
   localparam htrans_t HTRANS_NONSEQ = 2'b10;
   localparam htrans_t HTRANS_SEQ    = 2'b11;

   typedef enum logic [1:0] {
      REGION_NONE = 2'd0,
      REGION_REG  = 2'd1,
      REGION_PAL  = 2'd2
   } region_t;

   typedef enum logic [1:0] {
      ST_IDLE     = 2'd0,
      ST_WRITE    = 2'd1,
      ST_READ     = 2'd2,
      ST_PAL_WAIT = 2'd3
   } slave_state_t;

   localparam int NUM_REGS = 14;

   // ============================================================
   // register map, byte offsets from the block base
   // ============================================================
   localparam logic [11:0] OFS_TIMH      = 12'h000;
   localparam logic [11:0] OFS_TIMV      = 12'h004;
   localparam logic [11:0] OFS_POL       = 12'h008;
   localparam logic [11:0] OFS_LE        = 12'h00C;
   localparam logic [11:0] OFS_UPBASE    = 12'h010;
   localparam logic [11:0] OFS_LPBASE    = 12'h014;
   localparam logic [11:0] OFS_CTRL      = 12'h018;
   localparam logic [11:0] OFS_INTMSK    = 12'h01C;
   localparam logic [11:0] OFS_CRSR_CTRL = 12'hC00;
   localparam logic [11:0] OFS_CRSR_CFG  = 12'hC04;
   localparam logic [11:0] OFS_CRSR_PAL0 = 12'hC08;
   localparam logic [11:0] OFS_CRSR_PAL1 = 12'hC0C;
   localparam logic [11:0] OFS_CRSR_XY   = 12'hC10;
   localparam logic [11:0] OFS_CRSR_CLIP = 12'hC14;

   // palette window, one word per entry
   localparam logic [11:0] OFS_PAL_FIRST = 12'h200;
   localparam logic [11:0] OFS_PAL_LAST  = 12'h3FC;

endpackage

/* rtl/lcd_addr_decode.sv */
// Combinational address decode for the LCD block.
// LCD_BASE must be 4 KiB aligned. Unaligned or unmapped
// addresses decode to REGION_NONE.
`timescale 1ns/1ps

module lcd_addr_decode import lcd_ahb_pkg::*; #(
   parameter addr_t LCD_BASE = 32'hFFE1_0000
) (
   input  addr_t    addr,
   output region_t  region,
   output reg_idx_t reg_idx,
   output pal_idx_t pal_idx
);

   // wraps for addresses below the base, so the upper bits catch those too
   addr_t ofs;

   assign ofs     = addr - LCD_BASE;
   assign pal_idx = ofs[8:2];

   always_comb begin
      region  = REGION_NONE;
      reg_idx = '0;
      if (ofs[31:12] == '0 && ofs[1:0] == 2'b00) begin
         if (ofs[11:0] >= OFS_PAL_FIRST && ofs[11:0] <= OFS_PAL_LAST) begin
            region = REGION_PAL;
         end else begin
            region = REGION_REG;
            case (ofs[11:0])
               OFS_TIMH:      reg_idx = 4'd0;
               OFS_TIMV:      reg_idx = 4'd1;
               OFS_POL:       reg_idx = 4'd2;
               OFS_LE:        reg_idx = 4'd3;
               OFS_UPBASE:    reg_idx = 4'd4;
               OFS_LPBASE:    reg_idx = 4'd5;
               OFS_CTRL:      reg_idx = 4'd6;
               OFS_INTMSK:    reg_idx = 4'd7;
               OFS_CRSR_CTRL: reg_idx = 4'd8;
               OFS_CRSR_CFG:  reg_idx = 4'd9;
               OFS_CRSR_PAL0: reg_idx = 4'd10;
               OFS_CRSR_PAL1: reg_idx = 4'd11;
               OFS_CRSR_XY:   reg_idx = 4'd12;
               OFS_CRSR_CLIP: reg_idx = 4'd13;
               default:       region  = REGION_NONE;
            endcase
         end
      end
   end

endmodule

/* rtl/ahb_slave_ctrl.sv */
// AHB-Lite transfer control for the LCD slave.
// Register transfers and palette writes have zero wait states;
// a palette read inserts one wait state (HREADY low).
// HRESP is not provided, every transfer completes OKAY.
`timescale 1ns/1ps

module ahb_slave_ctrl import lcd_ahb_pkg::*; (
   input  logic     HCLK,
   input  logic     HRESET,
   input  logic     HSEL,
   input  logic     HWRITE,
   input  htrans_t  HTRANS,
   input  data_t    HWDATA,
   input  region_t  region,
   input  reg_idx_t reg_idx,
   input  pal_idx_t pal_idx,
   output logic     HREADY,
   output data_t    HRDATA,
   output logic     reg_wr,
   output reg_idx_t wr_reg_idx,
   output data_t    wdata,
   output logic     pal_wr,
   output logic     pal_rd,
   output pal_idx_t acc_pal_idx,
   input  data_t    reg_rdata,
   input  data_t    pal_rdata
);

   slave_state_t state;
   slave_state_t state_nxt;
   region_t      cap_region;
   logic         accept;

   // ============================================================
   // address phase
   // ============================================================
   assign HREADY = (state != ST_PAL_WAIT);
   assign accept = HSEL && HREADY &&
                   (HTRANS == HTRANS_NONSEQ || HTRANS == HTRANS_SEQ);

   always_comb begin
      state_nxt = ST_IDLE;
      if (state == ST_PAL_WAIT) begin
         // second cycle of the palette read, RAM output is ready then
         state_nxt = ST_READ;
      end else if (accept) begin
         if (HWRITE)
            state_nxt = ST_WRITE;
         else if (region == REGION_PAL)
            state_nxt = ST_PAL_WAIT;
         else
            state_nxt = ST_READ;
      end
   end

   always_ff @(posedge HCLK or posedge HRESET) begin
      if (HRESET) begin
         state       <= ST_IDLE;
         cap_region  <= REGION_NONE;
         wr_reg_idx  <= '0;
         acc_pal_idx <= '0;
      end else begin
         state <= state_nxt;
         if (accept) begin
            cap_region  <= region;
            wr_reg_idx  <= reg_idx;
            acc_pal_idx <= pal_idx;
         end
      end
   end

   // ============================================================
   // data phase
   // ============================================================
   assign wdata  = HWDATA;
   assign reg_wr = (state == ST_WRITE) && (cap_region == REGION_REG);
   assign pal_wr = (state == ST_WRITE) && (cap_region == REGION_PAL);
   assign pal_rd = (state == ST_PAL_WAIT);

   always_comb begin
      HRDATA = '0;
      if (state == ST_READ) begin
         case (cap_region)
            REGION_REG: HRDATA = reg_rdata;
            REGION_PAL: HRDATA = pal_rdata;
            default:    HRDATA = '0;
         endcase
      end
   end

   // wait state is exactly one cycle long
   a_pal_wait_single : assert property (@(posedge HCLK) disable iff (HRESET)
      !HREADY |=> HREADY);

   // only a palette read decoded in the previous address phase stalls the bus
   a_pal_wait_cause : assert property (@(posedge HCLK) disable iff (HRESET)
      !HREADY |-> $past(region) == REGION_PAL && !$past(HWRITE));

   // a write strobe goes to the one block decoded in its address phase
   a_wr_exclusive : assert property (@(posedge HCLK) disable iff (HRESET)
      (reg_wr || pal_wr) |-> reg_wr != pal_wr && $past(region) == cap_region);

endmodule

/* rtl/lcd_reg_bank.sv */
// LCD timing and cursor configuration registers.
// Index order follows the register map in lcd_ahb_pkg.
// All registers reset to zero.
`timescale 1ns/1ps

module lcd_reg_bank import lcd_ahb_pkg::*; (
   input  logic     HCLK,
   input  logic     HRESET,
   input  logic     reg_wr,
   input  reg_idx_t wr_reg_idx,
   input  data_t    wdata,
   input  reg_idx_t rd_idx,
   output data_t    reg_rdata,
   output data_t    lcd_timh,
   output data_t    lcd_timv,
   output data_t    lcd_pol,
   output data_t    lcd_le,
   output data_t    lcd_upbase,
   output data_t    lcd_lpbase,
   output data_t    lcd_ctrl,
   output data_t    lcd_intmsk,
   output data_t    crsr_ctrl,
   output data_t    crsr_cfg,
   output data_t    crsr_pal0,
   output data_t    crsr_pal1,
   output data_t    crsr_xy,
   output data_t    crsr_clip
);

   data_t regs [NUM_REGS];

   always_ff @(posedge HCLK or posedge HRESET) begin
      if (HRESET) begin
         for (int i = 0; i < NUM_REGS; i++)
            regs[i] <= '0;
      end else if (reg_wr && wr_reg_idx < NUM_REGS) begin
         regs[wr_reg_idx] <= wdata;
      end
   end

   // indices 14 and 15 are never decoded, read as zero anyway
   assign reg_rdata = (rd_idx < NUM_REGS) ? regs[rd_idx] : '0;

   // ============================================================
   // panel timing outputs
   // ============================================================
   assign lcd_timh   = regs[0];
   assign lcd_timv   = regs[1];
   assign lcd_pol    = regs[2];
   assign lcd_le     = regs[3];
   assign lcd_upbase = regs[4];
   assign lcd_lpbase = regs[5];
   assign lcd_ctrl   = regs[6];
   assign lcd_intmsk = regs[7];

   // cursor
   assign crsr_ctrl  = regs[8];
   assign crsr_cfg   = regs[9];
   assign crsr_pal0  = regs[10];
   assign crsr_pal1  = regs[11];
   assign crsr_xy    = regs[12];
   assign crsr_clip  = regs[13];

   // decode never hands out an index past the last register
   a_wr_idx_range : assert property (@(posedge HCLK) disable iff (HRESET)
      reg_wr |-> wr_reg_idx < NUM_REGS);

endmodule

/* rtl/lcd_pal_ram.sv */
// Colour palette RAM, 128 words, single port.
// Read data is registered, so it is valid one cycle after pal_rd.
// Contents are undefined until written.
`timescale 1ns/1ps

module lcd_pal_ram import lcd_ahb_pkg::*; (
   input  logic     HCLK,
   input  logic     pal_wr,
   input  logic     pal_rd,
   input  pal_idx_t idx,
   input  data_t    wdata,
   output data_t    pal_rdata
);

   localparam int DEPTH = 2 ** $bits(pal_idx_t);

   data_t mem [DEPTH];

   always_ff @(posedge HCLK) begin
      if (pal_wr)
         mem[idx] <= wdata;
      // hold last read word between reads
      if (pal_rd)
         pal_rdata <= mem[idx];
   end

endmodule

/* rtl/lcd_ahb_top.sv */
// AHB-Lite slave front end of the LCD panel controller.
// LCD_BASE must be 4 KiB aligned; the block decodes 4 KiB above it.
// All register values are driven out for the panel timing logic.
`timescale 1ns/1ps

module lcd_ahb_top import lcd_ahb_pkg::*; #(
   parameter addr_t LCD_BASE = 32'hFFE1_0000
) (
   input  logic    HCLK,
   input  logic    HRESET,
   input  logic    HSEL,
   input  addr_t   HADDR,
   input  logic    HWRITE,
   input  htrans_t HTRANS,
   input  data_t   HWDATA,
   output data_t   HRDATA,
   output logic    HREADY,
   output data_t   lcd_timh,
   output data_t   lcd_timv,
   output data_t   lcd_pol,
   output data_t   lcd_le,
   output data_t   lcd_upbase,
   output data_t   lcd_lpbase,
   output data_t   lcd_ctrl,
   output data_t   lcd_intmsk,
   output data_t   crsr_ctrl,
   output data_t   crsr_cfg,
   output data_t   crsr_pal0,
   output data_t   crsr_pal1,
   output data_t   crsr_xy,
   output data_t   crsr_clip
);

   region_t  region;
   reg_idx_t reg_idx;
   pal_idx_t pal_idx;
   logic     reg_wr;
   reg_idx_t wr_reg_idx;
   data_t    wdata;
   logic     pal_wr;
   logic     pal_rd;
   pal_idx_t acc_pal_idx;
   data_t    reg_rdata;
   data_t    pal_rdata;

   lcd_addr_decode #(
      .LCD_BASE (LCD_BASE)
   ) u_decode (
      .addr    (HADDR),
      .region  (region),
      .reg_idx (reg_idx),
      .pal_idx (pal_idx)
   );

   ahb_slave_ctrl u_ctrl (
      .HCLK        (HCLK),
      .HRESET      (HRESET),
      .HSEL        (HSEL),
      .HWRITE      (HWRITE),
      .HTRANS      (HTRANS),
      .HWDATA      (HWDATA),
      .region      (region),
      .reg_idx     (reg_idx),
      .pal_idx     (pal_idx),
      .HREADY      (HREADY),
      .HRDATA      (HRDATA),
      .reg_wr      (reg_wr),
      .wr_reg_idx  (wr_reg_idx),
      .wdata       (wdata),
      .pal_wr      (pal_wr),
      .pal_rd      (pal_rd),
      .acc_pal_idx (acc_pal_idx),
      .reg_rdata   (reg_rdata),
      .pal_rdata   (pal_rdata)
   );

   // read and write share the captured index
   lcd_reg_bank u_regs (
      .HCLK       (HCLK),
      .HRESET     (HRESET),
      .reg_wr     (reg_wr),
      .wr_reg_idx (wr_reg_idx),
      .wdata      (wdata),
      .rd_idx     (wr_reg_idx),
      .reg_rdata  (reg_rdata),
      .lcd_timh   (lcd_timh),
      .lcd_timv   (lcd_timv),
      .lcd_pol    (lcd_pol),
      .lcd_le     (lcd_le),
      .lcd_upbase (lcd_upbase),
      .lcd_lpbase (lcd_lpbase),
      .lcd_ctrl   (lcd_ctrl),
      .lcd_intmsk (lcd_intmsk),
      .crsr_ctrl  (crsr_ctrl),
      .crsr_cfg   (crsr_cfg),
      .crsr_pal0  (crsr_pal0),
      .crsr_pal1  (crsr_pal1),
      .crsr_xy    (crsr_xy),
      .crsr_clip  (crsr_clip)
   );

   lcd_pal_ram u_pal (
      .HCLK      (HCLK),
      .pal_wr    (pal_wr),
      .pal_rd    (pal_rd),
      .idx       (acc_pal_idx),
      .wdata     (wdata),
      .pal_rdata (pal_rdata)
   );

endmodule

/* verif/tb_lcd_ahb.sv */
// Testbench for the LCD AHB-Lite slave at the default LCD_BASE.
// Drives a pipelined AHB master and checks against a reference model.
// Palette entries are only read back after they have been written.
`timescale 1ns/1ps

module tb_lcd_ahb import lcd_ahb_pkg::*; ();

   localparam addr_t BASE       = 32'hFFE1_0000;
   localparam int    RST_CYCLES = 10;

   // register order as in the register map
   localparam logic [11:0] REG_OFS [NUM_REGS] = '{
      OFS_TIMH, OFS_TIMV, OFS_POL, OFS_LE, OFS_UPBASE, OFS_LPBASE, OFS_CTRL,
      OFS_INTMSK, OFS_CRSR_CTRL, OFS_CRSR_CFG, OFS_CRSR_PAL0, OFS_CRSR_PAL1,
      OFS_CRSR_XY, OFS_CRSR_CLIP
   };

   typedef struct packed {
      logic    sel;
      htrans_t trans;
      logic    write;
      addr_t   addr;
      data_t   data;
   } xfer_t;

   logic    HCLK;
   logic    HRESET;
   logic    HSEL;
   addr_t   HADDR;
   logic    HWRITE;
   htrans_t HTRANS;
   data_t   HWDATA;
   data_t   HRDATA;
   logic    HREADY;
   data_t   reg_out [NUM_REGS];

   data_t   ref_regs [NUM_REGS];
   data_t   ref_pal [128];
   xfer_t   xfer_q [$];
   int      pal_written [$];
   int      cycles = 0;
   int      issued = 0;
   int      rdata_errs = 0;
   int      reg_errs = 0;
   int      wait_errs = 0;

   lcd_ahb_top u_dut (
      .HCLK       (HCLK),
      .HRESET     (HRESET),
      .HSEL       (HSEL),
      .HADDR      (HADDR),
      .HWRITE     (HWRITE),
      .HTRANS     (HTRANS),
      .HWDATA     (HWDATA),
      .HRDATA     (HRDATA),
      .HREADY     (HREADY),
      .lcd_timh   (reg_out[0]),
      .lcd_timv   (reg_out[1]),
      .lcd_pol    (reg_out[2]),
      .lcd_le     (reg_out[3]),
      .lcd_upbase (reg_out[4]),
      .lcd_lpbase (reg_out[5]),
      .lcd_ctrl   (reg_out[6]),
      .lcd_intmsk (reg_out[7]),
      .crsr_ctrl  (reg_out[8]),
      .crsr_cfg   (reg_out[9]),
      .crsr_pal0  (reg_out[10]),
      .crsr_pal1  (reg_out[11]),
      .crsr_xy    (reg_out[12]),
      .crsr_clip  (reg_out[13])
   );

   initial begin
      HCLK = 1'b0;
      forever #2 HCLK = ~HCLK;
   end

   // limit grows with every queued bus cycle
   initial begin
      while (cycles <= 3 * issued + RST_CYCLES + 100) begin
         @(posedge HCLK);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", cycles);
      $display("Test failures found");
      $finish;
   end

   // ============================================================
   // reference model
   // ============================================================
   function automatic addr_t reg_addr(int i);
      return BASE + {20'h0, REG_OFS[i]};
   endfunction

   function automatic addr_t pal_addr(int p);
      return BASE + {20'h0, OFS_PAL_FIRST} + 32'(p * 4);
   endfunction

   // -1 when the address is not a register
   function automatic int reg_index(addr_t addr);
      addr_t ofs;
      ofs = addr - BASE;
      if (ofs >= 32'h1000 || ofs[1:0] != 2'b00)
         return -1;
      for (int i = 0; i < NUM_REGS; i++)
         if (ofs[11:0] == REG_OFS[i])
            return i;
      return -1;
   endfunction

   function automatic int pal_index(addr_t addr);
      addr_t ofs;
      ofs = addr - BASE;
      if (ofs >= 32'h1000 || ofs[1:0] != 2'b00)
         return -1;
      if (ofs[11:0] >= OFS_PAL_FIRST && ofs[11:0] <= OFS_PAL_LAST)
         return int'(ofs[8:2]);
      return -1;
   endfunction

   function automatic data_t expected_read(addr_t addr);
      if (reg_index(addr) >= 0)
         return ref_regs[reg_index(addr)];
      if (pal_index(addr) >= 0)
         return ref_pal[pal_index(addr)];
      return '0;
   endfunction

   task automatic model_write(addr_t addr, data_t data);
      if (reg_index(addr) >= 0)
         ref_regs[reg_index(addr)] = data;
      else if (pal_index(addr) >= 0)
         ref_pal[pal_index(addr)] = data;
   endtask

   // ============================================================
   // compare tasks
   // ============================================================
   task automatic check_rdata(data_t got, data_t exp, addr_t addr);
      if (got !== exp) begin
         rdata_errs++;
         $display("ERROR @%0t: read of %h returned %h, expected %h", $time, addr, got, exp);
      end
   endtask

   task automatic check_reg_out(data_t got, data_t exp, int idx);
      if (got !== exp) begin
         reg_errs++;
         $display("ERROR @%0t: register output %0d is %h, expected %h", $time, idx, got, exp);
      end
   endtask

   task automatic check_wait(int got, int exp, addr_t addr);
      if (got != exp) begin
         wait_errs++;
         $display("ERROR @%0t: access to %h took %0d wait cycles, expected %0d",
                  $time, addr, got, exp);
      end
   endtask

   task automatic check_outputs();
      for (int i = 0; i < NUM_REGS; i++)
         check_reg_out(reg_out[i], ref_regs[i], i);
   endtask

   // ============================================================
   // AHB master
   // ============================================================
   task automatic queue_xfer(logic sel, htrans_t trans, logic write, addr_t addr,
                             data_t data);
      xfer_t x;
      x.sel   = sel;
      x.trans = trans;
      x.write = write;
      x.addr  = addr;
      x.data  = data;
      xfer_q.push_back(x);
      issued++;
   endtask

   task automatic finish_data_phase(xfer_t x, int waits);
      int exp_waits;
      exp_waits = (!x.write && pal_index(x.addr) >= 0) ? 1 : 0;
      if (x.write)
         model_write(x.addr, x.data);
      else
         check_rdata(HRDATA, expected_read(x.addr), x.addr);
      check_wait(waits, exp_waits, x.addr);
   endtask

   // called 1 ns after a rising edge, returns at the same point
   task automatic run_pipelined();
      xfer_t cur;
      xfer_t dp;
      logic  dp_valid;
      int    waits;
      dp_valid = 1'b0;
      waits    = 0;
      while (xfer_q.size() > 0 || dp_valid) begin
         if (xfer_q.size() > 0) begin
            cur = xfer_q[0];
         end else begin
            cur.sel   = 1'b0;
            cur.trans = HTRANS_IDLE;
         end
         HSEL   = cur.sel;
         HTRANS = cur.trans;
         HWRITE = cur.write;
         HADDR  = cur.addr;
         HWDATA = (dp_valid && dp.write) ? dp.data : '0;
         // HREADY and HRDATA hold for the whole cycle
         if (HREADY) begin
            if (dp_valid)
               finish_data_phase(dp, waits);
            dp_valid = cur.sel && (cur.trans == HTRANS_NONSEQ || cur.trans == HTRANS_SEQ);
            dp       = cur;
            waits    = 0;
            if (xfer_q.size() > 0)
               void'(xfer_q.pop_front());
         end else if (dp_valid) begin
            waits++;
         end
         @(posedge HCLK);
         #1;
      end
      HSEL   = 1'b0;
      HTRANS = HTRANS_IDLE;
   endtask

   task automatic ahb_write(addr_t addr, data_t data);
      queue_xfer(1'b1, HTRANS_NONSEQ, 1'b1, addr, data);
      run_pipelined();
   endtask

   task automatic ahb_read(addr_t addr);
      queue_xfer(1'b1, HTRANS_NONSEQ, 1'b0, addr, '0);
      run_pipelined();
   endtask

   // ============================================================
   // tests
   // ============================================================
   initial begin
      data_t d;
      int    p;
      addr_t bad_addr [9];
      void'($urandom(32'h3a6));
      HRESET = 1'b1;
      HSEL   = 1'b0;
      HADDR  = '0;
      HWRITE = 1'b0;
      HTRANS = HTRANS_IDLE;
      HWDATA = '0;
      for (int i = 0; i < NUM_REGS; i++)
         ref_regs[i] = '0;
      repeat (RST_CYCLES) @(posedge HCLK);
      #1;
      HRESET = 1'b0;

      // reset values
      if (HREADY !== 1'b1) begin
         wait_errs++;
         $display("HREADY is not high after reset");
      end
      check_outputs();
      for (int i = 0; i < NUM_REGS; i++)
         queue_xfer(1'b1, HTRANS_NONSEQ, 1'b0, reg_addr(i), '0);
      run_pipelined();

      // each register, write then read back
      for (int i = 0; i < NUM_REGS; i++) begin
         d = $urandom();
         ahb_write(reg_addr(i), d);
         ahb_read(reg_addr(i));
         check_outputs();
      end

      // palette
      for (int k = 0; k < 16; k++) begin
         p = $urandom_range(127);
         pal_written.push_back(p);
         ahb_write(pal_addr(p), $urandom());
      end
      foreach (pal_written[k])
         ahb_read(pal_addr(pal_written[k]));

      // unmapped, unaligned and out-of-block addresses
      bad_addr = '{BASE + 32'h020, BASE + 32'h100, BASE + 32'h400, BASE + 32'hC18,
                   BASE + 32'h003, BASE + 32'h202, BASE - 32'h4, BASE + 32'h1000, 32'h0};
      foreach (bad_addr[k]) begin
         ahb_write(bad_addr[k], $urandom());
         ahb_read(bad_addr[k]);
      end
      check_outputs();
      for (int i = 0; i < NUM_REGS; i++)
         ahb_read(reg_addr(i));
      foreach (pal_written[k])
         ahb_read(pal_addr(pal_written[k]));

      // pipelined mix with idle, busy and deselected cycles
      for (int k = 0; k < 40; k++) begin
         d = $urandom();
         p = $urandom_range(NUM_REGS - 1);
         case ($urandom_range(5))
            0: begin
               queue_xfer(1'b1, HTRANS_NONSEQ, 1'b1, reg_addr(p), d);
               queue_xfer(1'b1, HTRANS_SEQ, 1'b0, reg_addr(p), '0);
            end
            1: begin
               p = $urandom_range(127);
               pal_written.push_back(p);
               queue_xfer(1'b1, HTRANS_NONSEQ, 1'b1, pal_addr(p), d);
               queue_xfer(1'b1, HTRANS_SEQ, 1'b0, pal_addr(p), '0);
            end
            2: queue_xfer(1'b1, HTRANS_IDLE, 1'b1, reg_addr(p), d);
            3: queue_xfer(1'b1, HTRANS_BUSY, 1'b1, reg_addr(p), d);
            4: queue_xfer(1'b0, HTRANS_NONSEQ, 1'b1, reg_addr(p), d);
            default: queue_xfer(1'b0, HTRANS_SEQ, 1'b1, pal_addr(p), d);
         endcase
      end
      run_pipelined();
      check_outputs();
      for (int i = 0; i < NUM_REGS; i++)
         queue_xfer(1'b1, HTRANS_NONSEQ, 1'b0, reg_addr(i), '0);
      foreach (pal_written[k])
         queue_xfer(1'b1, HTRANS_SEQ, 1'b0, pal_addr(pal_written[k]), '0);
      run_pipelined();

      $display("errors: read data %0d, register outputs %0d, wait states %0d",
               rdata_errs, reg_errs, wait_errs);
      if (rdata_errs + reg_errs + wait_errs == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

/* lcd_ahb.f */
rtl/lcd_ahb_pkg.sv
rtl/lcd_addr_decode.sv
rtl/ahb_slave_ctrl.sv
rtl/lcd_reg_bank.sv
rtl/lcd_pal_ram.sv
rtl/lcd_ahb_top.sv
verif/tb_lcd_ahb.sv

/* Makefile */
# Verilator simulation of the LCD AHB-Lite slave

TOP = tb_lcd_ahb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails unless it passes"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f lcd_ahb.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
